/* bench/stats_stimulus.txt */
# E kind count action (kind 0 in, 1 out, 2 ring update, 3 cpu) | F fill | S settle cycles
# W region reg data | R region reg expected | N region reg (no response expected)
S 20
R 0 00 00000000
R 0 01 00000000
R 0 02 00000000
R 0 03 00000000
R 0 04 00000000
R 0 05 00000000
R 0 06 00000000
E 0 07 0
E 1 05 0
R 0 00 00000007
R 0 01 00000005
E 2 09 0
E 3 06 1
E 3 04 2
E 3 03 0
E 3 02 3
S 20
R 0 03 00000009
R 0 04 00000006
R 0 05 00000004
F 00000010
F 0000002a
F 00000017
S 20
R 0 06 0000002a
F 00000005
S 20
R 0 06 0000002a
W 0 02 a5a5f00d
R 0 02 a5a5f00d
W 0 03 12345678
R 0 02 00000000
W 0 02 0000beef
W 3 02 11112222
R 0 02 0000beef
N 3 02
N 1 00
R 0 0c 00000000
R 0 00 00000007

/* bench/stats_top_tb.sv */
`default_nettype none

module stats_top_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam STIM_FILE = "bench/stats_stimulus.txt";
    // cycles a read may take before its response counts as missing
    localparam int RSP_WAIT = 4;

    logic                   clk_status;
    logic                   rst;
    stats_pkg::pkt_events_t pkt_events;
    stats_pkg::fill_level_t fill_level;
    csr_pkg::status_req_t   status_req;
    csr_pkg::status_rsp_t   status_rsp;

    // parsed stimulus with one entry per operation line
    byte         op_q[$];
    logic [31:0] f1_q[$];
    logic [31:0] f2_q[$];
    logic [31:0] f3_q[$];

    int          errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] lcg_state;

    // reference model of the counters and ctrl
    stats_pkg::stat_value_t m_in;
    stats_pkg::stat_value_t m_out;
    stats_pkg::stat_value_t m_dma;
    stats_pkg::stat_value_t m_match;
    stats_pkg::stat_value_t m_nomatch;
    stats_pkg::stat_value_t m_max;
    stats_pkg::stat_value_t m_ctrl;

    stats_top stats_top_i (
        .clk_status   (clk_status),
        .rst          (rst),
        .pkt_events_i (pkt_events),
        .fill_level_i (fill_level),
        .status_req_i (status_req),
        .status_rsp_o (status_rsp)
    );

    always #50 clk_status = ~clk_status;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // region in the top four bits, register number in the low byte
    function automatic logic [29:0] csr_addr(input logic [3:0] region, input logic [7:0] reg_num);
        return {region, 18'd0, reg_num};
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] reg_num);
        case (reg_num)
            stats_pkg::REG_IN_PKT:          return m_in;
            stats_pkg::REG_OUT_PKT:         return m_out;
            stats_pkg::REG_CTRL:            return m_ctrl;
            stats_pkg::REG_DMA_PKT:         return m_dma;
            stats_pkg::REG_CPU_MATCH_PKT:   return m_match;
            stats_pkg::REG_CPU_NOMATCH_PKT: return m_nomatch;
            stats_pkg::REG_MAX_FILL:        return m_max;
            default:                        return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("test run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // reads the operation lines and sizes the cycle budget
    task automatic load_stimulus(output bit ok);
        int          fd;
        int          budget;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        ok = 1'b0;
        budget = 3;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2) begin
                continue;
            end
            op = line.getc(0);
            if (op == "#") begin
                continue;
            end
            a = '0;
            b = '0;
            c = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
            op_q.push_back(op);
            f1_q.push_back(a);
            f2_q.push_back(b);
            f3_q.push_back(c);
            case (op)
                // each event takes at most three gap cycles and itself
                "E": budget += b * 4 + 1;
                "S": budget += a;
                "R": budget += RSP_WAIT + 3;
                "N": budget += RSP_WAIT + 2;
                default: budget += 2;
            endcase
        end
        $fclose(fd);
        cycle_limit = 2 * budget + 200;
        ok = 1'b1;
    endtask

    task automatic send_events(input logic [31:0] kind, input logic [31:0] count,
                               input logic [1:0] action);
        int   gap;
        logic decoy;
        for (int n = 0; n < count; n++) begin
            lcg_state = lcg_step(lcg_state);
            gap = lcg_state[17:16];
            decoy = lcg_state[20];
            // idle gap that may carry a partial handshake
            for (int g = 0; g < gap; g++) begin
                @(negedge clk_status);
                pkt_events = '0;
                if (decoy) begin
                    case (kind)
                        0: begin
                            pkt_events.in_valid = ~lcg_state[21];
                            pkt_events.in_eop   = lcg_state[21];
                        end
                        1: begin
                            pkt_events.out_valid = 1'b1;
                            pkt_events.out_eop   = 1'b1;
                        end
                        3: begin
                            pkt_events.cpu_valid  = 1'b1;
                            pkt_events.cpu_action = action;
                        end
                        default: pkt_events = '0;
                    endcase
                end
            end
            @(negedge clk_status);
            pkt_events = '0;
            case (kind)
                0: begin
                    pkt_events.in_valid = 1'b1;
                    pkt_events.in_eop   = 1'b1;
                    m_in++;
                end
                1: begin
                    pkt_events.out_valid = 1'b1;
                    pkt_events.out_eop   = 1'b1;
                    pkt_events.out_ready = 1'b1;
                    m_out++;
                end
                2: begin
                    pkt_events.rb_update_valid = 1'b1;
                    m_dma++;
                end
                default: begin
                    pkt_events.cpu_valid  = 1'b1;
                    pkt_events.cpu_ready  = 1'b1;
                    pkt_events.cpu_action = action;
                    if (action == 2'd1) begin
                        m_match++;
                    end else if (action == 2'd2) begin
                        m_nomatch++;
                    end
                end
            endcase
        end
        @(negedge clk_status);
        pkt_events = '0;
    endtask

    task automatic sample_fill(input logic [31:0] value);
        @(negedge clk_status);
        fill_level = value;
        if (value > m_max) begin
            m_max = value;
        end
        @(negedge clk_status);
        fill_level = '0;
    endtask

    task automatic write_reg(input logic [3:0] region, input logic [7:0] reg_num,
                             input logic [31:0] data);
        @(negedge clk_status);
        status_req = '0;
        status_req.addr = csr_addr(region, reg_num);
        status_req.write = 1'b1;
        status_req.writedata = data;
        @(negedge clk_status);
        status_req = '0;
        if (region == 4'd0) begin
            m_ctrl = (reg_num == stats_pkg::REG_CTRL) ? data : 32'd0;
        end
    endtask

    task automatic issue_read(input logic [3:0] region, input logic [7:0] reg_num);
        @(negedge clk_status);
        status_req = '0;
        status_req.addr = csr_addr(region, reg_num);
        status_req.read = 1'b1;
        @(negedge clk_status);
        status_req = '0;
    endtask

    task automatic read_reg(input logic [3:0] region, input logic [7:0] reg_num,
                            input logic [31:0] exp);
        int   wait_n;
        logic seen;
        // file value must agree with the counting rules
        check_value($sformatf("model register %h", reg_num), model_read(reg_num), exp);
        issue_read(region, reg_num);
        seen = 1'b0;
        wait_n = 0;
        while (!seen && wait_n < RSP_WAIT) begin
            @(negedge clk_status);
            wait_n++;
            seen = status_rsp.readdata_valid;
        end
        if (!seen) begin
            $display("no readdata_valid for read of region %h register %h", region, reg_num);
            errors++;
        end else begin
            if (wait_n != 1) begin
                $display("readdata_valid for register %h came %0d cycles late",
                         reg_num, wait_n - 1);
                errors++;
            end
            check_value($sformatf("readdata register %h", reg_num), status_rsp.readdata, exp);
            @(negedge clk_status);
            if (status_rsp.readdata_valid) begin
                $display("readdata_valid for register %h held longer than one cycle", reg_num);
                errors++;
            end
        end
    endtask

    task automatic read_no_rsp(input logic [3:0] region, input logic [7:0] reg_num);
        logic seen;
        issue_read(region, reg_num);
        seen = 1'b0;
        repeat (RSP_WAIT) begin
            @(negedge clk_status);
            seen = seen | status_rsp.readdata_valid;
        end
        if (seen) begin
            $display("unexpected readdata_valid for read of region %h register %h",
                     region, reg_num);
            errors++;
        end
    endtask

    task automatic run_stimulus();
        repeat (3) @(negedge clk_status);
        rst = 1'b0;
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "E": send_events(f1_q[i], f2_q[i], f3_q[i][1:0]);
                "F": sample_fill(f1_q[i]);
                "W": write_reg(f1_q[i][3:0], f2_q[i][7:0], f3_q[i]);
                "R": read_reg(f1_q[i][3:0], f2_q[i][7:0], f3_q[i]);
                "N": read_no_rsp(f1_q[i][3:0], f2_q[i][7:0]);
                "S": repeat (f1_q[i]) @(negedge clk_status);
                default: begin
                    $display("unknown operation on stimulus line %0d", i);
                    errors++;
                end
            endcase
        end
    endtask

    always @(posedge clk_status) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            errors++;
            finish_run();
        end
    end

    initial begin
        bit ok;
        clk_status = 1'b0;
        rst = 1'b1;
        pkt_events = '0;
        fill_level = '0;
        status_req = '0;
        errors = 0;
        cycles = 0;
        cycle_limit = 0;
        lcg_state = 32'h23cb;
        m_in = '0;
        m_out = '0;
        m_dma = '0;
        m_match = '0;
        m_nomatch = '0;
        m_max = '0;
        m_ctrl = '0;
        load_stimulus(ok);
        if (!ok) begin
            $display("could not open stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            run_stimulus();
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* files.f */
source/stats_pkg.sv
source/csr_pkg.sv
source/event_counters.sv
source/stats_scanner.sv
source/stats_fifo.sv
source/stats_table.sv
source/status_csr.sv
source/stats_top.sv
bench/stats_top_tb.sv

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int STATUS_AWIDTH = 30;
    // region select sits in the top address bits
    localparam int STAT_AWIDTH   = 4;
    // register number sits in the low address bits
    localparam int REG_AWIDTH    = 8;

    typedef logic [STAT_AWIDTH-1:0] region_t;

    localparam region_t TOP_REG = 4'd0;

    typedef struct packed {
        logic [STATUS_AWIDTH-1:0] addr;
        logic                     read;
        logic                     write;
        stats_pkg::stat_value_t   writedata;
    } status_req_t;

    typedef struct packed {
        stats_pkg::stat_value_t readdata;
        logic                   readdata_valid;
    } status_rsp_t;

endpackage

`default_nettype wire

/* source/event_counters.sv */
`default_nettype none

module event_counters (
    input  wire                     clk_status,
    input  wire                     rst,
    input  wire stats_pkg::pkt_events_t events_i,
    input  wire stats_pkg::fill_level_t fill_level_i,
    output stats_pkg::counter_set_t counters_o
);

    stats_pkg::counter_set_t cnt_q;

    logic in_hit;
    logic out_hit;
    logic cpu_hit;
    logic match_hit;
    logic nomatch_hit;

    // partial handshakes count nothing
    always_comb begin
        in_hit      = events_i.in_valid & events_i.in_eop;
        out_hit     = events_i.out_valid & events_i.out_eop & events_i.out_ready;
        cpu_hit     = events_i.cpu_valid & events_i.cpu_ready;
        match_hit   = cpu_hit & (events_i.cpu_action == stats_pkg::ACTION_MATCH);
        nomatch_hit = cpu_hit & (events_i.cpu_action == stats_pkg::ACTION_NOMATCH);
    end

    always_ff @(posedge clk_status) begin
        if (rst) begin
            cnt_q <= '0;
        end else begin
            if (in_hit) begin
                cnt_q.in_pkt <= cnt_q.in_pkt + 1'b1;
            end
            if (out_hit) begin
                cnt_q.out_pkt <= cnt_q.out_pkt + 1'b1;
            end
            // one ring-buffer update per DMA packet
            if (events_i.rb_update_valid) begin
                cnt_q.dma_pkt <= cnt_q.dma_pkt + 1'b1;
            end
            if (match_hit) begin
                cnt_q.cpu_match_pkt <= cnt_q.cpu_match_pkt + 1'b1;
            end
            if (nomatch_hit) begin
                cnt_q.cpu_nomatch_pkt <= cnt_q.cpu_nomatch_pkt + 1'b1;
            end
            // running maximum that only drops on reset
            if (fill_level_i > cnt_q.max_fill) begin
                cnt_q.max_fill <= fill_level_i;
            end
        end
    end

    assign counters_o = cnt_q;

endmodule

`default_nettype wire

/* source/stats_fifo.sv */
`default_nettype none

module stats_fifo (
    input  wire                        clk_status,
    input  wire                        rst,
    input  wire                        push_i,
    input  wire stats_pkg::stats_rec_t rec_i,
    input  wire                        pop_i,
    output stats_pkg::stats_rec_t      rec_o,
    output logic                       full_o,
    output logic                       empty_o
);

    stats_pkg::stats_rec_t mem [stats_pkg::STATS_FIFO_DEPTH];

    logic [$clog2(stats_pkg::STATS_FIFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(stats_pkg::STATS_FIFO_DEPTH)-1:0] rd_ptr_q;
    // one extra bit so a full FIFO is distinct from an empty one
    logic [$clog2(stats_pkg::STATS_FIFO_DEPTH):0]   count_q;

    assign full_o  = (count_q == stats_pkg::STATS_FIFO_DEPTH);
    assign empty_o = (count_q == 0);

    // head record shown without a read request
    assign rec_o = mem[rd_ptr_q];

    always_ff @(posedge clk_status) begin
        if (push_i) begin
            mem[wr_ptr_q] <= rec_i;
        end
    end

    always_ff @(posedge clk_status) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // depth is a power of two so pointers wrap on their own
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/stats_pkg.sv */
`default_nettype none

package stats_pkg;

    // counter and register word
    typedef logic [31:0] stat_value_t;
    // stats register address
    typedef logic [7:0]  stat_addr_t;
    // channel FIFO fill level
    typedef logic [31:0] fill_level_t;
    // descriptor action code from the CPU path
    typedef logic [1:0]  action_t;

    localparam action_t ACTION_MATCH   = 2'd1;
    localparam action_t ACTION_NOMATCH = 2'd2;

    // pipeline strobes sampled by the counters
    typedef struct packed {
        logic    in_valid;
        logic    in_eop;
        logic    out_valid;
        logic    out_eop;
        logic    out_ready;
        logic    rb_update_valid;
        logic    cpu_valid;
        logic    cpu_ready;
        action_t cpu_action;
    } pkt_events_t;

    typedef struct packed {
        stat_value_t in_pkt;
        stat_value_t out_pkt;
        stat_value_t dma_pkt;
        stat_value_t cpu_match_pkt;
        stat_value_t cpu_nomatch_pkt;
        fill_level_t max_fill;
    } counter_set_t;

    // one address/value update for the register table
    typedef struct packed {
        stat_addr_t  addr;
        stat_value_t value;
    } stats_rec_t;

    localparam stat_addr_t REG_IN_PKT          = 8'd0;
    localparam stat_addr_t REG_OUT_PKT         = 8'd1;
    localparam stat_addr_t REG_CTRL            = 8'd2;
    localparam stat_addr_t REG_DMA_PKT         = 8'd3;
    localparam stat_addr_t REG_CPU_MATCH_PKT   = 8'd4;
    localparam stat_addr_t REG_CPU_NOMATCH_PKT = 8'd5;
    localparam stat_addr_t REG_MAX_FILL        = 8'd6;

    // dma, match, no-match and max fill go through the record path
    localparam int N_SCANNED         = 4;
    localparam int STATS_FIFO_DEPTH  = 16;
    localparam int STATS_TABLE_DEPTH = 16;
    // worst-case cycles from a counter change to its table entry
    localparam int STATS_SETTLE      = 32;

endpackage

`default_nettype wire

/* source/stats_scanner.sv */
`default_nettype none

module stats_scanner (
    input  wire                          clk_status,
    input  wire                          rst,
    input  wire stats_pkg::counter_set_t counters_i,
    input  wire                          fifo_full_i,
    output logic                         push_o,
    output stats_pkg::stats_rec_t        rec_o
);

    logic [$clog2(stats_pkg::N_SCANNED)-1:0] slot_q;
    logic                                    run_q;

    // scanning starts the cycle after reset is released
    assign push_o = run_q & ~fifo_full_i;

    always_ff @(posedge clk_status) begin
        if (rst) begin
            run_q  <= 1'b0;
            slot_q <= '0;
        end else begin
            run_q <= 1'b1;
            // slot holds while the FIFO is full
            if (push_o) begin
                if (slot_q == stats_pkg::N_SCANNED - 1) begin
                    slot_q <= '0;
                end else begin
                    slot_q <= slot_q + 1'b1;
                end
            end
        end
    end

    // record built from live counters so a stalled slot picks up fresh values
    always_comb begin
        case (slot_q)
            0: begin
                rec_o.addr  = stats_pkg::REG_DMA_PKT;
                rec_o.value = counters_i.dma_pkt;
            end
            1: begin
                rec_o.addr  = stats_pkg::REG_CPU_MATCH_PKT;
                rec_o.value = counters_i.cpu_match_pkt;
            end
            2: begin
                rec_o.addr  = stats_pkg::REG_CPU_NOMATCH_PKT;
                rec_o.value = counters_i.cpu_nomatch_pkt;
            end
            default: begin
                rec_o.addr  = stats_pkg::REG_MAX_FILL;
                rec_o.value = counters_i.max_fill;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/stats_table.sv */
`default_nettype none

module stats_table (
    input  wire                         clk_status,
    input  wire                         rst,
    input  wire                         empty_i,
    input  wire stats_pkg::stats_rec_t  rec_i,
    output logic                        pop_o,
    input  wire stats_pkg::stat_addr_t  rd_addr_i,
    output stats_pkg::stat_value_t      rd_data_o
);

    stats_pkg::stat_value_t entry_q [stats_pkg::STATS_TABLE_DEPTH];

    logic wr_hit;
    logic rd_hit;

    // drain one record per cycle whenever one is waiting
    assign pop_o = ~empty_i;

    // records beyond the table are dropped
    assign wr_hit = pop_o & (rec_i.addr < stats_pkg::STATS_TABLE_DEPTH);
    assign rd_hit = (rd_addr_i < stats_pkg::STATS_TABLE_DEPTH);

    always_ff @(posedge clk_status) begin
        if (rst) begin
            for (int i = 0; i < stats_pkg::STATS_TABLE_DEPTH; i++) begin
                entry_q[i] <= '0;
            end
        end else if (wr_hit) begin
            entry_q[rec_i.addr[$clog2(stats_pkg::STATS_TABLE_DEPTH)-1:0]] <= rec_i.value;
        end
    end

    // combinational read port for the CSR
    always_comb begin
        if (rd_hit) begin
            rd_data_o = entry_q[rd_addr_i[$clog2(stats_pkg::STATS_TABLE_DEPTH)-1:0]];
        end else begin
            rd_data_o = '0;
        end
    end

endmodule

`default_nettype wire

/* source/stats_top.sv */
`default_nettype none

module stats_top (
    input  wire                          clk_status,
    input  wire                          rst,
    input  wire stats_pkg::pkt_events_t  pkt_events_i,
    input  wire stats_pkg::fill_level_t  fill_level_i,
    input  wire csr_pkg::status_req_t    status_req_i,
    output csr_pkg::status_rsp_t         status_rsp_o
);

    stats_pkg::counter_set_t counters;

    // scanner to FIFO
    logic                    push;
    stats_pkg::stats_rec_t   scan_rec;
    logic                    fifo_full;

    // FIFO to table
    logic                    pop;
    stats_pkg::stats_rec_t   head_rec;
    logic                    fifo_empty;

    // CSR read port into the table
    stats_pkg::stat_addr_t   table_addr;
    stats_pkg::stat_value_t  table_data;

    event_counters event_counters_i (
        .clk_status   (clk_status),
        .rst          (rst),
        .events_i     (pkt_events_i),
        .fill_level_i (fill_level_i),
        .counters_o   (counters)
    );

    stats_scanner stats_scanner_i (
        .clk_status  (clk_status),
        .rst         (rst),
        .counters_i  (counters),
        .fifo_full_i (fifo_full),
        .push_o      (push),
        .rec_o       (scan_rec)
    );

    stats_fifo stats_fifo_i (
        .clk_status (clk_status),
        .rst        (rst),
        .push_i     (push),
        .rec_i      (scan_rec),
        .pop_i      (pop),
        .rec_o      (head_rec),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty)
    );

    stats_table stats_table_i (
        .clk_status (clk_status),
        .rst        (rst),
        .empty_i    (fifo_empty),
        .rec_i      (head_rec),
        .pop_o      (pop),
        .rd_addr_i  (table_addr),
        .rd_data_o  (table_data)
    );

    // in/out packet counts bypass the record path
    status_csr status_csr_i (
        .clk_status   (clk_status),
        .rst          (rst),
        .req_i        (status_req_i),
        .in_pkt_i     (counters.in_pkt),
        .out_pkt_i    (counters.out_pkt),
        .table_addr_o (table_addr),
        .table_data_i (table_data),
        .rsp_o        (status_rsp_o)
    );

endmodule

`default_nettype wire

/* source/status_csr.sv */
`default_nettype none

module status_csr (
    input  wire                          clk_status,
    input  wire                          rst,
    input  wire csr_pkg::status_req_t    req_i,
    input  wire stats_pkg::stat_value_t  in_pkt_i,
    input  wire stats_pkg::stat_value_t  out_pkt_i,
    output stats_pkg::stat_addr_t        table_addr_o,
    input  wire stats_pkg::stat_value_t  table_data_i,
    output csr_pkg::status_rsp_t         rsp_o
);

    csr_pkg::status_req_t   req_q;
    csr_pkg::status_rsp_t   rsp_q;
    csr_pkg::region_t       region;
    stats_pkg::stat_addr_t  reg_addr;
    stats_pkg::stat_value_t ctrl_q;
    stats_pkg::stat_value_t rd_mux;
    logic                   top_hit;

    // region from the top bits, register number from the low bits
    assign region   = req_q.addr[csr_pkg::STATUS_AWIDTH-1 -: csr_pkg::STAT_AWIDTH];
    assign reg_addr = req_q.addr[csr_pkg::REG_AWIDTH-1:0];
    assign top_hit  = (region == csr_pkg::TOP_REG);

    // table data comes back in the cycle of the registered address
    assign table_addr_o = reg_addr;

    always_comb begin
        case (reg_addr)
            stats_pkg::REG_IN_PKT:  rd_mux = in_pkt_i;
            stats_pkg::REG_OUT_PKT: rd_mux = out_pkt_i;
            stats_pkg::REG_CTRL:    rd_mux = ctrl_q;
            default:                rd_mux = table_data_i;
        endcase
    end

    always_ff @(posedge clk_status) begin
        if (rst) begin
            req_q  <= '0;
            rsp_q  <= '0;
            ctrl_q <= '0;
        end else begin
            req_q <= req_i;
            // valid is a single-cycle pulse per read
            rsp_q.readdata_valid <= req_q.read & top_hit;
            if (req_q.read & top_hit) begin
                rsp_q.readdata <= rd_mux;
            end
            // any other TOP_REG write clears ctrl
            if (req_q.write & top_hit) begin
                if (reg_addr == stats_pkg::REG_CTRL) begin
                    ctrl_q <= req_q.writedata;
                end else begin
                    ctrl_q <= '0;
                end
            end
        end
    end

    assign rsp_o = rsp_q;

endmodule

`default_nettype wire
